//--- src/isa_pkg.sv
package isa_pkg;

	typedef logic [15:0] instr_t;
	typedef logic [4:0]  opcode_t;
	typedef logic [3:0]  reg_idx_t;

	////////////////////////////////////////////////////////////
	// Register indices
	////////////////////////////////////////////////////////////
	localparam reg_idx_t SP_IDX  = 4'd8;
	localparam reg_idx_t T_IDX   = 4'd9;
	localparam reg_idx_t IH_IDX  = 4'd10;
	localparam reg_idx_t RA_IDX  = 4'd11;
	localparam reg_idx_t EPC_IDX = 4'd12;
	localparam reg_idx_t NO_REG  = 4'd15;   // Reads as zero, never written

	////////////////////////////////////////////////////////////
	// Major opcodes, bits 15 to 11
	////////////////////////////////////////////////////////////
	localparam opcode_t OP_ADDIU       = 5'b01001;
	localparam opcode_t OP_ADDIU3      = 5'b01000;
	localparam opcode_t OP_GROUP_SP    = 5'b01100;   // ADDSP, MTSP
	localparam opcode_t OP_GROUP_RRR   = 5'b11100;   // ADDU, SUBU
	localparam opcode_t OP_GROUP_RR    = 5'b11101;   // AND, OR, CMP, MFPC
	localparam opcode_t OP_LI          = 5'b01101;
	localparam opcode_t OP_CMPI        = 5'b01110;
	localparam opcode_t OP_GROUP_IH    = 5'b11110;   // MFIH, MTIH
	localparam opcode_t OP_GROUP_SHIFT = 5'b00110;   // SLL, SRA
	localparam opcode_t OP_NOP         = 5'b00001;

	// Sub-function codes
	localparam logic [2:0] FN_ADDSP    = 3'b011;     // Bits 10 to 8
	localparam logic [2:0] FN_MTSP     = 3'b100;
	localparam logic [1:0] FN_ADDU     = 2'b01;      // Bits 1 to 0
	localparam logic [1:0] FN_SUBU     = 2'b11;
	localparam logic [4:0] FN_AND      = 5'b01100;   // Bits 4 to 0
	localparam logic [4:0] FN_OR       = 5'b01101;
	localparam logic [4:0] FN_CMP      = 5'b01010;
	localparam logic [4:0] FN_PC_GROUP = 5'b00000;
	localparam logic [2:0] FN_MFPC     = 3'b010;     // Bits 7 to 5
	localparam logic       FN_MFIH     = 1'b0;       // Bit 0
	localparam logic       FN_MTIH     = 1'b1;
	localparam logic [1:0] FN_SLL      = 2'b00;      // Bits 1 to 0
	localparam logic [1:0] FN_SRA      = 2'b11;

endpackage

//--- src/core_pkg.sv
package core_pkg;

	typedef logic [15:0] data_t;
	typedef logic [15:0] addr_t;

	////////////////////////////////////////////////////////////
	// ALU operations
	////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		ALU_ADD   = 4'b0000,
		ALU_AND   = 4'b0001,
		ALU_OR    = 4'b0010,
		ALU_SLL   = 4'b0011,
		ALU_SRA   = 4'b0101,
		ALU_SUB   = 4'b0110,
		ALU_EQUAL = 4'b0111,   // Zero when equal
		ALU_MOVE  = 4'b1001
	} alu_op_e;

	// Operand sources for A and B
	typedef enum logic [1:0] {
		SEL_R1_R2 = 2'b00,
		SEL_R1_IM = 2'b01,
		SEL_R1_NU = 2'b10,
		SEL_IM_NU = 2'b11
	} opnd_sel_e;

endpackage

//--- src/instr_decode.sv
module instr_decode (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                instr_valid,
	input  isa_pkg::instr_t     instruction,
	input  core_pkg::addr_t     pc,
	output logic                dec_valid,
	output core_pkg::alu_op_e   dec_op,
	output core_pkg::opnd_sel_e dec_sel,
	output isa_pkg::reg_idx_t   dec_src_a,
	output isa_pkg::reg_idx_t   dec_src_b,
	output isa_pkg::reg_idx_t   dec_dst,
	output core_pkg::data_t     dec_imm
);

	import isa_pkg::*;
	import core_pkg::*;

	opcode_t   opc;
	reg_idx_t  rx;
	reg_idx_t  ry;
	reg_idx_t  rz;
	data_t     imm8_s;
	data_t     imm8_z;
	data_t     imm4_s;
	data_t     shamt;

	logic      nxt_wr;
	alu_op_e   nxt_op;
	opnd_sel_e nxt_sel;
	reg_idx_t  nxt_src_a;
	reg_idx_t  nxt_src_b;
	reg_idx_t  nxt_dst;
	data_t     nxt_imm;

	assign opc    = instruction[15:11];
	assign rx     = {1'b0, instruction[10:8]};
	assign ry     = {1'b0, instruction[7:5]};
	assign rz     = {1'b0, instruction[4:2]};
	assign imm8_s = {{8{instruction[7]}}, instruction[7:0]};
	assign imm8_z = {8'd0, instruction[7:0]};
	assign imm4_s = {{12{instruction[3]}}, instruction[3:0]};
	assign shamt  = (instruction[4:2] == 3'd0) ? 16'd8 : {13'd0, instruction[4:2]};   // 0 means 8

	////////////////////////////////////////////////////////////
	// Field decode
	////////////////////////////////////////////////////////////
	always_comb begin
		nxt_wr    = 1'b0;
		nxt_op    = ALU_ADD;
		nxt_sel   = SEL_R1_R2;
		nxt_src_a = NO_REG;
		nxt_src_b = NO_REG;
		nxt_dst   = NO_REG;
		nxt_imm   = '0;
		case (opc)
			OP_ADDIU, OP_ADDIU3: begin
				nxt_wr    = 1'b1;
				nxt_sel   = SEL_R1_IM;
				nxt_src_a = rx;
				nxt_imm   = (opc == OP_ADDIU) ? imm8_s : imm4_s;
				nxt_dst   = (opc == OP_ADDIU) ? rx : ry;
			end
			OP_GROUP_SP: begin
				if (instruction[10:8] == FN_ADDSP) begin
					nxt_wr    = 1'b1;
					nxt_sel   = SEL_R1_IM;
					nxt_src_a = SP_IDX;
					nxt_imm   = imm8_s;
					nxt_dst   = SP_IDX;
				end else if (instruction[10:8] == FN_MTSP) begin
					nxt_wr    = 1'b1;
					nxt_op    = ALU_MOVE;
					nxt_sel   = SEL_R1_NU;
					nxt_src_a = ry;
					nxt_dst   = SP_IDX;
				end
			end
			OP_GROUP_RRR: begin
				if (instruction[1:0] == FN_ADDU || instruction[1:0] == FN_SUBU) begin
					nxt_wr    = 1'b1;
					nxt_op    = (instruction[1:0] == FN_SUBU) ? ALU_SUB : ALU_ADD;
					nxt_src_a = rx;
					nxt_src_b = ry;
					nxt_dst   = rz;
				end
			end
			OP_GROUP_RR: begin
				case (instruction[4:0])
					FN_AND, FN_OR, FN_CMP: begin
						nxt_wr    = 1'b1;
						nxt_src_a = rx;
						nxt_src_b = ry;
						if (instruction[4:0] == FN_CMP) begin
							nxt_op  = ALU_EQUAL;
							nxt_dst = T_IDX;
						end else begin
							nxt_op  = (instruction[4:0] == FN_AND) ? ALU_AND : ALU_OR;
							nxt_dst = rx;
						end
					end
					FN_PC_GROUP: begin
						if (instruction[7:5] == FN_MFPC) begin
							nxt_wr  = 1'b1;
							nxt_op  = ALU_MOVE;
							nxt_sel = SEL_IM_NU;
							nxt_imm = pc;
							nxt_dst = rx;
						end
					end
					default: ;   // JR, SLT, SRAV act as NOP
				endcase
			end
			OP_LI: begin
				nxt_wr  = 1'b1;
				nxt_op  = ALU_MOVE;
				nxt_sel = SEL_IM_NU;
				nxt_imm = imm8_z;
				nxt_dst = rx;
			end
			OP_CMPI: begin
				nxt_wr    = 1'b1;
				nxt_op    = ALU_EQUAL;
				nxt_sel   = SEL_R1_IM;
				nxt_src_a = rx;
				nxt_imm   = imm8_s;
				nxt_dst   = T_IDX;
			end
			OP_GROUP_IH: begin
				nxt_wr    = 1'b1;
				nxt_op    = ALU_MOVE;
				nxt_sel   = SEL_R1_NU;
				nxt_src_a = (instruction[0] == FN_MTIH) ? rx : IH_IDX;
				nxt_dst   = (instruction[0] == FN_MFIH) ? rx : IH_IDX;
			end
			OP_GROUP_SHIFT: begin
				if (instruction[1:0] == FN_SLL || instruction[1:0] == FN_SRA) begin
					nxt_wr    = 1'b1;
					nxt_op    = (instruction[1:0] == FN_SRA) ? ALU_SRA : ALU_SLL;
					nxt_sel   = SEL_R1_IM;
					nxt_src_a = ry;
					nxt_imm   = shamt;
					nxt_dst   = rx;
				end
			end
			OP_NOP: ;
			default: ;   // Memory, branch and unknown opcodes
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			dec_valid <= 1'b0;
		else
			dec_valid <= instr_valid & nxt_wr;
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			dec_op    <= nxt_op;
			dec_sel   <= nxt_sel;
			dec_src_a <= nxt_src_a;
			dec_src_b <= nxt_src_b;
			dec_dst   <= nxt_dst;
			dec_imm   <= nxt_imm;
		end
	end

endmodule

//--- src/alu_execute.sv
module alu_execute (
	input  logic                dec_valid,
	input  core_pkg::alu_op_e   dec_op,
	input  core_pkg::opnd_sel_e dec_sel,
	input  isa_pkg::reg_idx_t   dec_src_a,
	input  isa_pkg::reg_idx_t   dec_src_b,
	input  isa_pkg::reg_idx_t   dec_dst,
	input  core_pkg::data_t     dec_imm,
	input  core_pkg::data_t     rd_data_a,
	input  core_pkg::data_t     rd_data_b,
	output isa_pkg::reg_idx_t   rd_addr_a,
	output isa_pkg::reg_idx_t   rd_addr_b,
	output logic                ex_valid,
	output isa_pkg::reg_idx_t   ex_reg,
	output core_pkg::data_t     ex_data
);

	import core_pkg::*;

	data_t      opnd_a;
	data_t      opnd_b;
	data_t      result;
	logic [3:0] shift;

	assign rd_addr_a = dec_src_a;
	assign rd_addr_b = dec_src_b;

	////////////////////////////////////////////////////////////
	// Operand select
	////////////////////////////////////////////////////////////
	always_comb begin
		case (dec_sel)
			SEL_R1_R2: begin
				opnd_a = rd_data_a;
				opnd_b = rd_data_b;
			end
			SEL_R1_IM: begin
				opnd_a = rd_data_a;
				opnd_b = dec_imm;
			end
			SEL_R1_NU: begin
				opnd_a = rd_data_a;
				opnd_b = '0;
			end
			default: begin
				opnd_a = dec_imm;   // MFPC, LI
				opnd_b = '0;
			end
		endcase
	end

	assign shift = opnd_b[3:0];   // Amounts 1 to 8

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////
	always_comb begin
		case (dec_op)
			ALU_ADD:   result = opnd_a + opnd_b;
			ALU_SUB:   result = opnd_a - opnd_b;
			ALU_AND:   result = opnd_a & opnd_b;
			ALU_OR:    result = opnd_a | opnd_b;
			ALU_SLL:   result = opnd_a << shift;
			ALU_SRA:   result = $signed(opnd_a) >>> shift;
			ALU_EQUAL: result = (opnd_a == opnd_b) ? 16'd0 : 16'd1;
			ALU_MOVE:  result = opnd_a;
			default:   result = '0;
		endcase
	end

	assign ex_valid = dec_valid;
	assign ex_reg   = dec_dst;
	assign ex_data  = result;

endmodule

//--- src/reg_result.sv
module reg_result #(
	parameter core_pkg::data_t SP_RESET = 16'hBF00
) (
	input  logic              clk,
	input  logic              rst_n,
	input  isa_pkg::reg_idx_t rd_addr_a,
	input  isa_pkg::reg_idx_t rd_addr_b,
	input  logic              ex_valid,
	input  isa_pkg::reg_idx_t ex_reg,
	input  core_pkg::data_t   ex_data,
	output core_pkg::data_t   rd_data_a,
	output core_pkg::data_t   rd_data_b,
	output logic              wb_valid,
	output isa_pkg::reg_idx_t wb_reg,
	output core_pkg::data_t   wb_data
);

	import isa_pkg::*;
	import core_pkg::*;

	data_t regs [16];   // R0-R7, then SP, T, IH, RA, EPC

	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= (reg_idx_t'(i) == SP_IDX) ? SP_RESET : '0;
		end else if (ex_valid) begin
			regs[ex_reg] <= ex_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			wb_valid <= 1'b0;
		else
			wb_valid <= ex_valid;
	end

	// Write-back copy of the register write
	always_ff @(posedge clk) begin
		if (ex_valid) begin
			wb_reg  <= ex_reg;
			wb_data <= ex_data;
		end
	end

endmodule

//--- src/mips16_core.sv
module mips16_core #(
	parameter core_pkg::data_t SP_RESET = 16'hBF00
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              instr_valid,
	input  isa_pkg::instr_t   instruction,
	input  core_pkg::addr_t   pc,
	output logic              wb_valid,
	output isa_pkg::reg_idx_t wb_reg,
	output core_pkg::data_t   wb_data
);

	import isa_pkg::*;
	import core_pkg::*;

	logic      dec_valid;
	alu_op_e   dec_op;
	opnd_sel_e dec_sel;
	reg_idx_t  dec_src_a;
	reg_idx_t  dec_src_b;
	reg_idx_t  dec_dst;
	data_t     dec_imm;

	reg_idx_t  rd_addr_a;
	reg_idx_t  rd_addr_b;
	data_t     rd_data_a;
	data_t     rd_data_b;
	logic      ex_valid;
	reg_idx_t  ex_reg;
	data_t     ex_data;

	instr_decode u_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instruction (instruction),
		.pc          (pc),
		.dec_valid   (dec_valid),
		.dec_op      (dec_op),
		.dec_sel     (dec_sel),
		.dec_src_a   (dec_src_a),
		.dec_src_b   (dec_src_b),
		.dec_dst     (dec_dst),
		.dec_imm     (dec_imm)
	);

	alu_execute u_execute (
		.dec_valid (dec_valid),
		.dec_op    (dec_op),
		.dec_sel   (dec_sel),
		.dec_src_a (dec_src_a),
		.dec_src_b (dec_src_b),
		.dec_dst   (dec_dst),
		.dec_imm   (dec_imm),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.ex_valid  (ex_valid),
		.ex_reg    (ex_reg),
		.ex_data   (ex_data)
	);

	reg_result #(
		.SP_RESET (SP_RESET)
	) u_result (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.ex_valid  (ex_valid),
		.ex_reg    (ex_reg),
		.ex_data   (ex_data),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wb_valid  (wb_valid),
		.wb_reg    (wb_reg),
		.wb_data   (wb_data)
	);

endmodule

//--- dv/mips16_core_properties.sv
module mips16_core_properties #(
	parameter core_pkg::data_t SP_RESET = 16'hBF00
) (
	input logic              clk,
	input logic              rst_n,
	input logic              instr_valid,
	input isa_pkg::instr_t   instruction,
	input core_pkg::addr_t   pc,
	input logic              wb_valid,
	input isa_pkg::reg_idx_t wb_reg,
	input core_pkg::data_t   wb_data
);

	import isa_pkg::*;
	import core_pkg::*;

	int       error_count = 0;
	data_t    shadow [16];
	reg_idx_t rx;
	reg_idx_t ry;
	reg_idx_t rz;
	data_t    sext8;
	data_t    sext4;
	logic [3:0] amt;

	logic     exp_wr;
	reg_idx_t exp_dst;
	data_t    exp_val;

	logic     p1_valid;
	reg_idx_t p1_reg;
	data_t    p1_data;
	logic     p2_valid;
	reg_idx_t p2_reg;
	data_t    p2_data;

	assign rx    = reg_idx_t'(instruction[10:8]);
	assign ry    = reg_idx_t'(instruction[7:5]);
	assign rz    = reg_idx_t'(instruction[4:2]);
	assign sext8 = data_t'($signed(instruction[7:0]));
	assign sext4 = data_t'($signed(instruction[3:0]));
	assign amt   = (instruction[4:2] == 3'd0) ? 4'd8 : {1'b0, instruction[4:2]};

	////////////////////////////////////////////////////////////
	// Expected result of the instruction on the input
	////////////////////////////////////////////////////////////
	always_comb begin
		exp_wr  = 1'b1;
		exp_dst = rx;
		exp_val = '0;
		case (instruction[15:11])
			OP_ADDIU: exp_val = shadow[rx] + sext8;
			OP_ADDIU3: begin
				exp_dst = ry;
				exp_val = shadow[rx] + sext4;
			end
			OP_GROUP_SP: begin
				exp_dst = SP_IDX;
				if (instruction[10:8] == FN_ADDSP)
					exp_val = shadow[SP_IDX] + sext8;
				else if (instruction[10:8] == FN_MTSP)
					exp_val = shadow[ry];
				else
					exp_wr = 1'b0;   // BTEQZ and friends
			end
			OP_GROUP_RRR: begin
				exp_dst = rz;
				if (instruction[1:0] == FN_ADDU)
					exp_val = shadow[rx] + shadow[ry];
				else if (instruction[1:0] == FN_SUBU)
					exp_val = shadow[rx] - shadow[ry];
				else
					exp_wr = 1'b0;
			end
			OP_GROUP_RR: begin
				if (instruction[4:0] == FN_AND)
					exp_val = shadow[rx] & shadow[ry];
				else if (instruction[4:0] == FN_OR)
					exp_val = shadow[rx] | shadow[ry];
				else if (instruction[4:0] == FN_CMP) begin
					exp_dst = T_IDX;
					exp_val = (shadow[rx] == shadow[ry]) ? 16'd0 : 16'd1;
				end else if (instruction[4:0] == FN_PC_GROUP && instruction[7:5] == FN_MFPC)
					exp_val = pc;
				else
					exp_wr = 1'b0;   // JR, SLT, SRAV
			end
			OP_LI: exp_val = {8'd0, instruction[7:0]};
			OP_CMPI: begin
				exp_dst = T_IDX;
				exp_val = (shadow[rx] == sext8) ? 16'd0 : 16'd1;
			end
			OP_GROUP_IH: begin
				if (instruction[0] == FN_MTIH) begin
					exp_dst = IH_IDX;
					exp_val = shadow[rx];
				end else
					exp_val = shadow[IH_IDX];
			end
			OP_GROUP_SHIFT: begin
				if (instruction[1:0] == FN_SLL)
					exp_val = shadow[ry] << amt;
				else if (instruction[1:0] == FN_SRA)
					exp_val = data_t'($signed(shadow[ry]) >>> amt);
				else
					exp_wr = 1'b0;
			end
			default: exp_wr = 1'b0;   // NOP, memory, branches
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++)
				shadow[i] <= (reg_idx_t'(i) == SP_IDX) ? SP_RESET : '0;
			p1_valid <= 1'b0;
			p2_valid <= 1'b0;
		end else begin
			if (instr_valid && exp_wr)
				shadow[exp_dst] <= exp_val;
			p1_valid <= instr_valid && exp_wr;
			p2_valid <= p1_valid;
		end
	end

	// Two-stage delay to line up with write-back
	always_ff @(posedge clk) begin
		p1_reg  <= exp_dst;
		p1_data <= exp_val;
		p2_reg  <= p1_reg;
		p2_data <= p1_data;
	end

	////////////////////////////////////////////////////////////
	// Write-back checks
	////////////////////////////////////////////////////////////
	a_reset_idle: assert property (@(posedge clk) !rst_n |=> !wb_valid)
		else begin
			error_count = error_count + 1;
			$error("error %0t wb_valid: got %b expected 0", $time, $sampled(wb_valid));
		end

	a_wb_valid: assert property (@(posedge clk) disable iff (!rst_n) wb_valid == p2_valid)
		else begin
			error_count = error_count + 1;
			$error("error %0t wb_valid: got %b expected %b", $time,
				$sampled(wb_valid), $sampled(p2_valid));
		end

	a_wb_reg: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid && p2_valid |-> wb_reg == p2_reg)
		else begin
			error_count = error_count + 1;
			$error("error %0t wb_reg: got %0d expected %0d", $time,
				$sampled(wb_reg), $sampled(p2_reg));
		end

	a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid && p2_valid |-> wb_data == p2_data)
		else begin
			error_count = error_count + 1;
			$error("error %0t wb_data: got %h expected %h", $time,
				$sampled(wb_data), $sampled(p2_data));
		end

endmodule

bind mips16_core mips16_core_properties #(
	.SP_RESET (SP_RESET)
) u_props (
	.clk         (clk),
	.rst_n       (rst_n),
	.instr_valid (instr_valid),
	.instruction (instruction),
	.pc          (pc),
	.wb_valid    (wb_valid),
	.wb_reg      (wb_reg),
	.wb_data     (wb_data)
);

//--- dv/mips16_core_tb.sv
module mips16_core_tb;

	import isa_pkg::*;
	import core_pkg::*;

	localparam data_t SP_INIT = 16'h7F3C;

	logic     clk;
	logic     rst_n;
	logic     instr_valid;
	instr_t   instruction;
	addr_t    pc;
	logic     wb_valid;
	reg_idx_t wb_reg;
	data_t    wb_data;
	int       seed;
	int       timeout_errors;

	mips16_core #(
		.SP_RESET (SP_INIT)
	) UUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instruction (instruction),
		.pc          (pc),
		.wb_valid    (wb_valid),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data)
	);

	always #2 clk = ~clk;

	task automatic issue(input instr_t word);
		@(posedge clk);
		#1;
		instr_valid = 1'b1;
		instruction = word;
		pc          = pc + 16'd2;
	endtask

	task automatic go_idle;
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
	endtask

	task automatic drain_pipeline;
		int cycles;
		int quiet;
		cycles = 0;
		quiet  = 0;
		while (quiet < 4 && cycles < 64) begin
			@(posedge clk);
			#1;
			quiet = wb_valid ? 0 : quiet + 1;
			cycles++;
		end
		if (quiet < 4) begin
			timeout_errors++;
			$display("error: write-back still busy after 64 cycles at time %0t", $time);
		end
	endtask

	task automatic issue_random_kept;
		instr_t w;
		int     k;
		w = instr_t'($random(seed));
		k = {$random(seed)} % 10;
		case (k)
			0: w[15:11] = OP_ADDIU;
			1: w[15:11] = OP_ADDIU3;
			2: w = {OP_GROUP_SP, w[8] ? FN_ADDSP : FN_MTSP, w[7:0]};
			3: w = {OP_GROUP_RRR, w[10:2], w[0] ? FN_ADDU : FN_SUBU};
			4: w = {OP_GROUP_RR, w[10:5], w[0] ? FN_AND : FN_OR};
			5: w = {OP_GROUP_RR, w[10:5], FN_CMP};
			6: w = {OP_GROUP_RR, w[10:8], FN_MFPC, FN_PC_GROUP};
			7: w[15:11] = w[0] ? OP_LI : OP_CMPI;
			8: w[15:11] = OP_GROUP_IH;
			default: w = {OP_GROUP_SHIFT, w[10:2], w[0] ? FN_SLL : FN_SRA};
		endcase
		issue(w);
	endtask

	initial begin
		clk            = 1'b0;
		rst_n          = 1'b0;
		instr_valid    = 1'b0;
		instruction    = {OP_NOP, 11'd0};
		pc             = '0;
		seed           = 32'he199_1741;
		timeout_errors = 0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		drain_pipeline();

		////////////////////////////////////////////////////////////
		// Directed part
		////////////////////////////////////////////////////////////
		for (int r = 0; r < 8; r++)
			issue({OP_LI, 3'(r), 8'($random(seed))});
		issue({OP_GROUP_SP, FN_ADDSP, 8'h00});   // SP still at reset value
		issue({OP_GROUP_SP, FN_ADDSP, 8'hFD});
		issue({OP_GROUP_SP, FN_MTSP, 3'd2, 5'd0});
		issue({OP_GROUP_SP, FN_ADDSP, 8'h00});
		issue({OP_GROUP_IH, 3'd3, 7'd0, FN_MTIH});
		issue({OP_GROUP_IH, 3'd5, 7'd0, FN_MFIH});
		issue({OP_GROUP_RRR, 3'd1, 3'd2, 3'd3, FN_ADDU});
		issue({OP_GROUP_RRR, 3'd3, 3'd3, 3'd4, FN_ADDU});   // Uses r3 just written
		issue({OP_NOP, 11'd0});
		issue({OP_GROUP_RRR, 3'd4, 3'd1, 3'd4, FN_SUBU});
		issue({OP_GROUP_RR, 3'd4, 3'd2, FN_AND});
		issue({OP_GROUP_RR, 3'd4, 3'd7, FN_OR});
		issue(16'h9A40);                                     // LW, dropped
		issue({OP_GROUP_RR, 3'd4, 3'd4, FN_CMP});
		issue({OP_GROUP_RR, 3'd4, 3'd5, FN_CMP});
		issue({OP_GROUP_RR, 3'd6, FN_MFPC, FN_PC_GROUP});
		issue({OP_GROUP_RR, 3'd1, 3'd0, 5'd0});              // JR
		issue({OP_ADDIU, 3'd6, 8'h80});
		issue({OP_ADDIU3, 3'd6, 3'd7, 1'b0, 4'h9});
		issue(16'h1005);                                     // B
		issue({OP_LI, 3'd0, 8'h05});
		issue({OP_CMPI, 3'd0, 8'h05});
		issue({OP_LI, 3'd0, 8'h80});
		issue({OP_CMPI, 3'd0, 8'h80});                       // Sign extension differs
		issue({OP_GROUP_RR, 3'd1, 3'd2, 5'b00010});          // SLT
		issue({OP_LI, 3'd6, 8'h81});
		issue({OP_GROUP_SHIFT, 3'd7, 3'd6, 3'd0, FN_SLL});  // Negative source for SRA
		for (int a = 0; a < 8; a++) begin
			issue({OP_GROUP_SHIFT, 3'd5, 3'd6, 3'(a), FN_SLL});
			issue({OP_GROUP_SHIFT, 3'd4, 3'd7, 3'(a), FN_SRA});
		end
		go_idle();
		drain_pipeline();

		// Random kept instructions
		repeat (200) issue_random_kept();
		go_idle();
		drain_pipeline();

		$display("checks done: %0d assertion errors, %0d timeout errors",
			UUT.u_props.error_count, timeout_errors);
		if (UUT.u_props.error_count == 0 && timeout_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- flist.f
src/isa_pkg.sv
src/core_pkg.sv
src/instr_decode.sv
src/alu_execute.sv
src/reg_result.sv
src/mips16_core.sv
dv/mips16_core_properties.sv
dv/mips16_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mips16_core_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	-$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
